// ==== uart_cmd_pkg.sv ====
`default_nettype none

package uart_cmd_pkg;

  // 50 MHz clock, 115200 baud
  localparam int CLKS_PER_BIT = 434;

  // rx sampled half way into each bit
  localparam int SAMPLE_POINT = CLKS_PER_BIT / 2;

  // 20 frames of 11 bits before a missing reply is given up
  localparam int REPLY_TIMEOUT_CLKS = 20 * 11 * CLKS_PER_BIT;

  // write flag, 7-bit register address, write data
  typedef logic [15:0] cmd_t;

  typedef logic [7:0] byte_t;

  // counts clocks within one bit
  typedef logic [8:0] baud_cnt_t;

  // start, 8 data, parity, stop
  typedef logic [3:0] bit_idx_t;

  typedef logic [16:0] wait_cnt_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND_HI,
    ST_SEND_LO,
    ST_WAIT_REPLY
  } engine_state_t;

endpackage

`default_nettype wire

// ==== uart_frame_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_frame_tx (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                tx_start,
  input  wire uart_cmd_pkg::byte_t tx_byte,
  output logic                     tx_done,
  output logic                     tx
);

  import uart_cmd_pkg::*;

  logic [10:0] frame;
  logic        busy;
  baud_cnt_t   baud_cnt;
  bit_idx_t    bit_idx;
  logic        bit_end;
  logic        last_bit;

  assign bit_end  = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
  assign last_bit = (bit_idx == 4'd10);

  // last clock of the stop bit
  assign tx_done = busy && bit_end && last_bit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end else if (tx_start) begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      // start bit goes out right away
      tx       <= 1'b0;
    end else if (busy) begin
      if (bit_end) begin
        baud_cnt <= '0;
        if (last_bit) begin
          busy <= 1'b0;
          tx   <= 1'b1;
        end else begin
          bit_idx <= bit_idx + 4'd1;
          tx      <= frame[9];
        end
      end else begin
        baud_cnt <= baud_cnt + 9'd1;
      end
    end
  end

  // start, data msb first, odd parity, stop
  always_ff @(posedge clk) begin
    if (tx_start) begin
      frame <= {1'b0, tx_byte, ~^tx_byte, 1'b1};
    end else if (busy && bit_end) begin
      frame <= {frame[9:0], 1'b1};
    end
  end

endmodule

`default_nettype wire

// ==== uart_frame_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_frame_rx (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                rx,
  output logic                     rx_valid,
  output uart_cmd_pkg::byte_t      rx_byte,
  output logic                     rx_good,
  output logic                     rx_busy
);

  import uart_cmd_pkg::*;

  logic      rx_meta;
  logic      rx_sync;
  logic      rx_prev;
  logic      fall_edge;
  logic      start_chk;
  baud_cnt_t baud_cnt;
  bit_idx_t  bit_idx;
  logic      parity_bit;
  logic      sample_start;
  logic      sample_bit;

  // two-flop synchronizer, line idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall_edge    = rx_prev && !rx_sync;
  assign sample_start = start_chk && (baud_cnt == baud_cnt_t'(SAMPLE_POINT));
  // one bit time after the previous mid-bit sample
  assign sample_bit   = rx_busy && (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_chk <= 1'b0;
      rx_busy   <= 1'b0;
      baud_cnt  <= '0;
      bit_idx   <= '0;
      rx_valid  <= 1'b0;
      rx_good   <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (start_chk) begin
        if (sample_start) begin
          start_chk <= 1'b0;
          baud_cnt  <= '0;
          bit_idx   <= 4'd1;
          // line back high by mid start bit means a glitch
          rx_busy   <= !rx_sync;
        end else begin
          baud_cnt <= baud_cnt + 9'd1;
        end
      end else if (rx_busy) begin
        if (sample_bit) begin
          baud_cnt <= '0;
          bit_idx  <= bit_idx + 4'd1;
          if (bit_idx == 4'd10) begin
            rx_busy  <= 1'b0;
            rx_valid <= 1'b1;
            // odd parity over data and parity, stop must be high
            rx_good  <= (^{rx_byte, parity_bit}) && rx_sync;
          end
        end else begin
          baud_cnt <= baud_cnt + 9'd1;
        end
      end else if (fall_edge) begin
        start_chk <= 1'b1;
        baud_cnt  <= '0;
      end
    end
  end

  // data shifted in msb first
  always_ff @(posedge clk) begin
    if (sample_bit) begin
      if (bit_idx <= 4'd8) begin
        rx_byte <= {rx_byte[6:0], rx_sync};
      end else if (bit_idx == 4'd9) begin
        parity_bit <= rx_sync;
      end
    end
  end

endmodule

`default_nettype wire

// ==== uart_cmd_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_engine (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire uart_cmd_pkg::cmd_t  cmd_in,
  input  wire logic                cmd_vld,
  output logic                     cmd_rdy,
  output logic                     tx_start,
  output uart_cmd_pkg::byte_t      tx_byte,
  input  wire logic                tx_done,
  input  wire logic                rx_valid,
  input  wire uart_cmd_pkg::byte_t rx_byte,
  input  wire logic                rx_good,
  input  wire logic                rx_busy,
  output uart_cmd_pkg::byte_t      read_data,
  output logic                     read_rdy,
  output logic                     read_err
);

  import uart_cmd_pkg::*;

  engine_state_t state;
  cmd_t          cmd_reg;
  wait_cnt_t     wait_cnt;
  logic          accept;
  logic          is_write;
  logic          timeout;

  assign accept   = cmd_vld && cmd_rdy;
  assign is_write = cmd_reg[15];
  assign timeout  = (wait_cnt == wait_cnt_t'(REPLY_TIMEOUT_CLKS - 1));

  // flag and address byte first, data byte only on writes
  assign tx_byte = (state == ST_SEND_LO) ? cmd_reg[7:0] : cmd_reg[15:8];

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_reg <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      cmd_rdy   <= 1'b1;
      tx_start  <= 1'b0;
      wait_cnt  <= '0;
      read_data <= '0;
      read_rdy  <= 1'b0;
      read_err  <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state    <= ST_SEND_HI;
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
          end
        end
        ST_SEND_HI: begin
          if (tx_done) begin
            if (is_write) begin
              state    <= ST_SEND_LO;
              tx_start <= 1'b1;
            end else begin
              state    <= ST_WAIT_REPLY;
              wait_cnt <= '0;
            end
          end
        end
        ST_SEND_LO: begin
          if (tx_done) begin
            state   <= ST_IDLE;
            cmd_rdy <= 1'b1;
          end
        end
        ST_WAIT_REPLY: begin
          if (rx_valid) begin
            if (rx_good) begin
              read_data <= rx_byte;
              read_rdy  <= 1'b1;
            end else begin
              read_err <= 1'b1;
            end
            state   <= ST_IDLE;
            cmd_rdy <= 1'b1;
          end else if (!rx_busy) begin
            // timer holds while a reply frame is coming in
            if (timeout) begin
              read_err <= 1'b1;
              state    <= ST_IDLE;
              cmd_rdy  <= 1'b1;
            end else begin
              wait_cnt <= wait_cnt + 17'd1;
            end
          end
        end
        default: begin
          state   <= ST_IDLE;
          cmd_rdy <= 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== uart_cmd_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_top (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire uart_cmd_pkg::cmd_t  cmd_in,
  input  wire logic                cmd_vld,
  input  wire logic                rx,
  output logic                     cmd_rdy,
  output logic                     tx,
  output uart_cmd_pkg::byte_t      read_data,
  output logic                     read_rdy,
  output logic                     read_err
);

  import uart_cmd_pkg::*;

  logic  tx_start;
  byte_t tx_byte;
  logic  tx_done;
  logic  rx_valid;
  byte_t rx_byte;
  logic  rx_good;
  logic  rx_busy;

  uart_cmd_engine i_uart_cmd_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_good   (rx_good),
    .rx_busy   (rx_busy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_frame_tx i_uart_frame_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  // receiver runs all the time, engine filters its results
  uart_frame_rx i_uart_frame_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .rx_good  (rx_good),
    .rx_busy  (rx_busy)
  );

endmodule

`default_nettype wire

// ==== uart_cmd_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_sva (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic cmd_vld,
  input wire logic cmd_rdy,
  input wire logic tx,
  input wire logic read_rdy,
  input wire logic read_err
);

  // a read ends either good or bad
  strobes_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(read_rdy && read_err)
  ) else $error("read_rdy and read_err high in the same cycle");

  accept_drops_rdy: assert property (
    @(posedge clk) disable iff (!rst_n) (cmd_vld && cmd_rdy) |=> !cmd_rdy
  ) else $error("cmd_rdy still high after an accepted command");

  // no frame in flight while ready
  idle_line_high: assert property (
    @(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx
  ) else $error("tx low while cmd_rdy is high");

  strobe_ends_command: assert property (
    @(posedge clk) disable iff (!rst_n) (read_rdy || read_err) |-> !$past(cmd_rdy)
  ) else $error("read result strobe without a command in progress");

endmodule

`default_nettype wire

// ==== tb_uart_cmd.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_uart_cmd;

  import uart_cmd_pkg::*;

  localparam int NUM_CMDS    = 40;
  localparam int FRAME_CLKS  = 11 * CLKS_PER_BIT;
  // reply window of 20 frames plus some slack
  localparam int REPLY_LIMIT = 20 * FRAME_CLKS + 4 * CLKS_PER_BIT;
  // window already partly used up by the stop bit and the quiet check
  localparam int REPLY_MIN   = 20 * FRAME_CLKS - 2 * CLKS_PER_BIT;

  logic  clk;
  logic  rst_n;
  cmd_t  cmd_in;
  logic  cmd_vld;
  logic  rx;
  logic  cmd_rdy;
  logic  tx;
  byte_t read_data;
  logic  read_rdy;
  logic  read_err;

  integer seed;
  int     error_count;
  int     tests_passed;
  int     tests_failed;
  logic   timed_out;
  byte_t  last_read;
  byte_t  tx_bytes[$];

  uart_cmd_top i_uart_cmd_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  bind uart_cmd_top uart_cmd_sva i_uart_cmd_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx       (tx),
    .read_rdy (read_rdy),
    .read_err (read_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic wait_ready();
    int cnt;
    cnt = 0;
    while (!cmd_rdy && !timed_out) begin
      @(posedge clk);
      cnt++;
      if (cnt > 2 * FRAME_CLKS) begin
        $display("cmd_rdy did not come back in time at %0t", $time);
        error_count++;
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic issue_command(input cmd_t cmd);
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    // stray request while the port is busy
    @(posedge clk);
    cmd_in  <= ~cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  // device side, decodes one frame from tx at mid-bit
  task automatic receive_frame();
    logic [9:0] bits;
    int         cnt;
    cnt = 0;
    while (tx !== 1'b0 && !timed_out) begin
      @(posedge clk);
      cnt++;
      if (cnt > 4 * CLKS_PER_BIT) begin
        $display("no start bit seen on tx at %0t", $time);
        error_count++;
        timed_out = 1'b1;
      end
    end
    if (!timed_out) begin
      repeat (CLKS_PER_BIT / 2) @(posedge clk);
      check_flag("tx start bit", 1'b0, tx);
      for (int i = 9; i >= 0; i--) begin
        repeat (CLKS_PER_BIT) @(posedge clk);
        bits[i] = tx;
      end
      // ones over data and parity must be odd
      check_flag("tx parity", 1'b1, ^bits[9:1]);
      check_flag("tx stop bit", 1'b1, bits[0]);
      tx_bytes.push_back(bits[9:2]);
    end
  endtask

  task automatic expect_frame(input byte_t expected);
    receive_frame();
    if (tx_bytes.size() != 0) begin
      check_byte("tx frame", expected, tx_bytes.pop_front());
    end
  endtask

  task automatic send_frame(input byte_t data, input logic bad_parity);
    logic [10:0] frame;
    frame = {1'b0, data, ~^data ^ bad_parity, 1'b1};
    for (int i = 10; i >= 0; i--) begin
      @(posedge clk);
      rx <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic serve_read(input int earliest, input int limit, input logic good,
                            input byte_t data);
    int   cnt;
    logic got_rdy;
    logic got_err;
    cnt     = 0;
    got_rdy = 1'b0;
    got_err = 1'b0;
    while (!got_rdy && !got_err && !timed_out) begin
      @(posedge clk);
      got_rdy = read_rdy;
      got_err = read_err;
      cnt++;
      if (cnt > limit) begin
        $display("no read result at %0t", $time);
        error_count++;
        timed_out = 1'b1;
      end
    end
    if (!timed_out) begin
      if (cnt < earliest) begin
        $display("read result came too early at %0t", $time);
        error_count++;
      end
      check_flag("read_rdy", good, got_rdy);
      check_flag("read_err", !good, got_err);
      check_flag("cmd_rdy", 1'b1, cmd_rdy);
      if (good) begin
        last_read = data;
      end
      check_byte("read_data", last_read, read_data);
    end
  endtask

  // line idle and no result strobes for a while
  task automatic check_quiet(input int cycles);
    int bad;
    bad = 0;
    if (!timed_out) begin
      repeat (cycles) begin
        @(posedge clk);
        if (tx !== 1'b1 || read_rdy !== 1'b0 || read_err !== 1'b0) begin
          bad++;
        end
      end
      if (bad != 0) begin
        $display("unexpected frame or result strobe before %0t", $time);
        error_count++;
      end
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] choice;
    cmd_t        cmd;
    byte_t       reply;
    int          errors_before;
    seed         = 84;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    last_read    = '0;
    rst_n        = 1'b0;
    cmd_in       = '0;
    cmd_vld      = 1'b0;
    rx           = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_flag("tx", 1'b1, tx);
    check_flag("cmd_rdy", 1'b1, cmd_rdy);
    check_flag("read_rdy", 1'b0, read_rdy);
    check_flag("read_err", 1'b0, read_err);

    for (int n = 0; n < NUM_CMDS; n++) begin
      if (timed_out) break;
      errors_before = error_count;
      rnd    = $random(seed);
      cmd    = rnd[15:0];
      rnd    = $random(seed);
      reply  = rnd[7:0];
      rnd    = $random(seed);
      choice = rnd % 32'd100;
      // first one is an unanswered read
      if (n == 0) begin
        cmd[15] = 1'b0;
        choice  = 32'd99;
      end
      wait_ready();
      issue_command(cmd);
      expect_frame(cmd[15:8]);
      if (cmd[15]) begin
        expect_frame(cmd[7:0]);
        wait_ready();
      end else begin
        check_quiet(2 * CLKS_PER_BIT);
        if (choice < 32'd85) begin
          fork
            send_frame(reply, choice >= 32'd70);
            serve_read(10 * CLKS_PER_BIT, 12 * CLKS_PER_BIT, choice < 32'd70, reply);
          join
        end else begin
          serve_read(REPLY_MIN, REPLY_LIMIT, 1'b0, reply);
        end
      end
      check_quiet(2 * CLKS_PER_BIT);
      if (error_count == errors_before) begin
        tests_passed++;
        $display("cmd %0d wr=%0b %h ok", n, cmd[15], cmd);
      end else begin
        tests_failed++;
        $display("cmd %0d wr=%0b %h had errors", n, cmd[15], cmd);
      end
    end

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (error_count == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
uart_cmd_pkg.sv
uart_frame_tx.sv
uart_frame_rx.sv
uart_cmd_engine.sv
uart_cmd_top.sv
uart_cmd_sva.sv
tb_uart_cmd.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_uart_cmd
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
